// File: src/busPkg.sv
package busPkg;

	// command on the bus, valid for the single cycle it is not opIdle
	typedef enum logic [1:0] {
		opIdle  = 2'd0,
		opRead  = 2'd1,
		opWrite = 2'd2
	} busOpT;

	typedef struct packed {
		busOpT       op;
		logic [11:0] addr;
		logic [7:0]  wrData;
	} busReqT;

	// address map, memory lives below uartBase
	localparam logic [11:0] uartBase   = 12'h800; // port 0 data
	localparam logic [11:0] port1Data  = 12'h801;
	localparam logic [11:0] statusAddr = 12'h802;

	localparam logic [11:0] mailbox0   = 12'h7F0; // byte from port 0
	localparam logic [11:0] mailbox1   = 12'h7F1; // byte from port 1

	// write source of the data memory
	typedef enum logic [1:0] {
		srcBus = 2'd0,
		srcRx0 = 2'd1,
		srcRx1 = 2'd2
	} srcSelT;

endpackage

// File: src/serialPkg.sv
package serialPkg;

	// transmitter frame phases
	typedef enum logic [1:0] {
		txIdle     = 2'd0,
		txStartBit = 2'd1,
		txDataBits = 2'd2,
		txStopBit  = 2'd3
	} txStateT;

	// receiver frame phases
	typedef enum logic [1:0] {
		rxIdle     = 2'd0,
		rxStartBit = 2'd1,
		rxDataBits = 2'd2,
		rxStopBit  = 2'd3
	} rxStateT;

	// one port's view in the status word
	// port 1 sits in bits 3:2, port 0 in bits 1:0
	typedef struct packed {
		logic busy;
		logic overrun;
	} portStatusT;

endpackage

// File: src/uartTx.sv
`timescale 1ns/1ps
module uartTx #(
	parameter int clksPerBit = 16
) (
	input  logic       KEY,
	input  logic       rstN,
	input  logic       txStart,
	input  logic [7:0] txData,
	output logic       txLine,
	output logic       busy
);
	import serialPkg::*;

	localparam int cntW = $clog2(clksPerBit);

	txStateT         state;
	logic [cntW-1:0] bitCnt;   // cycles spent in the current bit
	logic [2:0]      bitIdx;   // data bit on the line
	logic [7:0]      shiftReg;
	logic            bitDone;

	assign bitDone = bitCnt == cntW'(clksPerBit - 1);
	assign busy    = state != txIdle; // start through stop

	always_ff @(posedge KEY) begin
		if (!rstN) begin
			state  <= txIdle;
			bitCnt <= '0;
			bitIdx <= '0;
			txLine <= 1'b1; // line idles high
		end else begin
			bitCnt <= bitDone ? '0 : bitCnt + 1'b1;
			case (state)
				txIdle: begin
					bitCnt <= '0;
					if (txStart) begin
						state  <= txStartBit;
						txLine <= 1'b0;
					end
				end
				txStartBit: begin
					if (bitDone) begin
						state  <= txDataBits;
						bitIdx <= '0;
						txLine <= shiftReg[0]; // LSB first
					end
				end
				txDataBits: begin
					if (bitDone) begin
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7) begin
							state  <= txStopBit;
							txLine <= 1'b1;
						end else begin
							txLine <= shiftReg[1]; // shift lands this same edge
						end
					end
				end
				default: begin
					if (bitDone) state <= txIdle;
				end
			endcase
		end
	end

	always_ff @(posedge KEY) begin
		if (state == txIdle && txStart) shiftReg <= txData;
		else if (state == txDataBits && bitDone) shiftReg <= shiftReg >> 1;
	end

endmodule

// File: src/uartRx.sv
`timescale 1ns/1ps
module uartRx #(
	parameter int clksPerBit = 16
) (
	input  logic       KEY,
	input  logic       rstN,
	input  logic       rxIn,     // already synchronized
	input  logic       rxClear,
	output logic       rxReady,
	output logic [7:0] rxData
);
	import serialPkg::*;

	localparam int cntW    = $clog2(clksPerBit);
	localparam int halfBit = clksPerBit / 2;

	rxStateT         state;
	logic [cntW-1:0] bitCnt;
	logic [2:0]      bitIdx;
	logic [7:0]      shiftReg;
	logic            bitDone;
	logic            halfDone;
	logic            frameOk;

	assign bitDone  = bitCnt == cntW'(clksPerBit - 1);
	assign halfDone = bitCnt == cntW'(halfBit - 1);

	// good stop bit and a free (or freeing) holding register
	assign frameOk = state == rxStopBit && bitDone && rxIn && (!rxReady || rxClear);

	always_ff @(posedge KEY) begin
		if (!rstN) begin
			state   <= rxIdle;
			bitCnt  <= '0;
			bitIdx  <= '0;
			rxReady <= 1'b0;
		end else begin
			if (rxClear) rxReady <= 1'b0;
			if (frameOk) rxReady <= 1'b1; // wins over a same-cycle clear
			case (state)
				rxIdle: begin
					bitCnt <= '0;
					if (!rxIn) state <= rxStartBit; // falling edge
				end
				rxStartBit: begin
					if (halfDone) begin
						bitCnt <= '0;
						bitIdx <= '0;
						state  <= rxIn ? rxIdle : rxDataBits; // glitch goes back
					end else begin
						bitCnt <= bitCnt + 1'b1;
					end
				end
				rxDataBits: begin
					if (bitDone) begin
						bitCnt <= '0;
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7) state <= rxStopBit;
					end else begin
						bitCnt <= bitCnt + 1'b1;
					end
				end
				default: begin
					// mid stop bit, frame is kept or dropped here
					if (bitDone) begin
						bitCnt <= '0;
						state  <= rxIdle;
					end else begin
						bitCnt <= bitCnt + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge KEY) begin
		if (state == rxDataBits && bitDone) shiftReg <= {rxIn, shiftReg[7:1]}; // LSB first
		if (frameOk) rxData <= shiftReg;
	end

endmodule

// File: src/uartPort.sv
`timescale 1ns/1ps
module uartPort #(
	parameter int clksPerBit = 16
) (
	input  logic                  KEY,
	input  logic                  rstN,
	input  logic                  txStart,
	input  logic [7:0]            txData,
	input  logic                  rxClear,
	input  logic                  rxLine,
	output logic                  txLine,
	output logic                  rxReady,
	output logic [7:0]            rxData,
	output serialPkg::portStatusT status
);
	logic [1:0] rxSync; // two-flop synchronizer
	logic       txBusy;

	always_ff @(posedge KEY) begin
		if (!rstN) rxSync <= 2'b11; // idle line, no false start
		else rxSync <= {rxSync[0], rxLine};
	end

	uartTx #(.clksPerBit(clksPerBit)) iUartTx (
		.KEY     (KEY),
		.rstN    (rstN),
		.txStart (txStart),
		.txData  (txData),
		.txLine  (txLine),
		.busy    (txBusy)
	);

	uartRx #(.clksPerBit(clksPerBit)) iUartRx (
		.KEY     (KEY),
		.rstN    (rstN),
		.rxIn    (rxSync[1]),
		.rxClear (rxClear),
		.rxReady (rxReady),
		.rxData  (rxData)
	);

	assign status.busy    = txBusy;
	assign status.overrun = 1'b0; // sticky bit is kept by the arbiter

endmodule

// File: src/portArbiter.sv
`timescale 1ns/1ps
module portArbiter (
	input  logic                        KEY,
	input  logic                        rstN,
	input  busPkg::busReqT              busReq,
	input  serialPkg::portStatusT [1:0] status,
	input  logic [1:0]                  rxReady,
	output logic [1:0]                  txStart,
	output logic [7:0]                  txData,
	output logic [1:0]                  rxClear,
	output logic                        memWe,
	output logic [11:0]                 memAddr,
	output logic [1:0]                  memSrc,
	output logic                        rdIsStatus,
	output logic [7:0]                  statusWord
);
	import busPkg::*;
	import serialPkg::*;

	logic [1:0]       overrun;  // sticky, cleared by a status read
	logic [1:0]       portBusy;
	logic [1:0]       portWr;
	logic [1:0]       storeSel;
	logic             isRead;
	logic             isWrite;
	logic             busMemWr;
	logic             storeOk;
	srcSelT           src;
	portStatusT [1:0] statusOut;

	assign isRead   = busReq.op == opRead;
	assign isWrite  = busReq.op == opWrite;
	assign busMemWr = isWrite && busReq.addr < uartBase;

	assign portWr[0] = isWrite && busReq.addr == uartBase;
	assign portWr[1] = isWrite && busReq.addr == port1Data;
	assign portBusy  = {status[1].busy, status[0].busy};

	// launch only on an idle port
	assign txStart = portWr & ~portBusy;
	assign txData  = busReq.wrData;

	assign rdIsStatus = isRead && busReq.addr == statusAddr;

	always_ff @(posedge KEY) begin
		if (!rstN) overrun <= '0;
		else if (rdIsStatus) overrun <= '0; // sampled by this same read
		else overrun <= overrun | (portWr & portBusy);
	end

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			statusOut[i].busy    = portBusy[i];
			statusOut[i].overrun = overrun[i];
		end
	end

	assign statusWord = 8'(statusOut);

	// single address port, so any bus read or memory write holds stores back
	assign storeOk     = !busMemWr && !isRead;
	assign storeSel[0] = storeOk && rxReady[0];
	assign storeSel[1] = storeOk && rxReady[1] && !rxReady[0]; // port 0 first
	assign rxClear     = storeSel;

	always_comb begin
		memAddr = busReq.addr;
		src     = srcBus;
		if (storeSel[0]) begin
			memAddr = mailbox0;
			src     = srcRx0;
		end else if (storeSel[1]) begin
			memAddr = mailbox1;
			src     = srcRx1;
		end
	end

	assign memSrc = src;
	assign memWe  = busMemWr || (|storeSel);

endmodule

// File: src/dataMemory.sv
`timescale 1ns/1ps
module dataMemory #(
	parameter int memWords = 2048
) (
	input  logic        KEY,
	input  logic        rstN,
	input  logic [7:0]  busData,
	input  logic [7:0]  rxData0,
	input  logic [7:0]  rxData1,
	input  logic        memWe,
	input  logic [11:0] memAddr,
	input  logic [1:0]  memSrc,
	input  logic        rdEn,
	input  logic        rdIsStatus,
	input  logic [7:0]  statusWord,
	output logic [7:0]  rdData,
	output logic        rdValid
);
	import busPkg::*;

	localparam int idxW = $clog2(memWords);

	logic [7:0]      mem [memWords];
	srcSelT          srcSel;
	logic [7:0]      wrByte;
	logic            inRange;  // address falls inside the array
	logic [idxW-1:0] idx;

	assign srcSel  = srcSelT'(memSrc);
	assign inRange = 32'(memAddr) < memWords;
	assign idx     = memAddr[idxW-1:0];

	always_comb begin
		case (srcSel)
			srcRx0:  wrByte = rxData0;
			srcRx1:  wrByte = rxData1;
			default: wrByte = busData;
		endcase
	end

	always_ff @(posedge KEY) begin
		if (memWe && inRange) mem[idx] <= wrByte;
		if (rdEn) begin
			if (rdIsStatus) rdData <= statusWord;
			else if (inRange) rdData <= mem[idx];
			else rdData <= '0; // port data addresses read as zero
		end
	end

	always_ff @(posedge KEY) begin
		if (!rstN) rdValid <= 1'b0;
		else rdValid <= rdEn;
	end

endmodule

// File: src/serialBridgeTop.sv
`timescale 1ns/1ps
module serialBridgeTop #(
	parameter int clksPerBit = 16
) (
	input  logic           KEY,
	input  logic           rstN,
	input  busPkg::busReqT busReq,
	input  logic [1:0]     rxLine,
	output logic [1:0]     txLine,
	output logic [7:0]     rdData,
	output logic           rdValid
);
	import busPkg::*;
	import serialPkg::*;

	localparam int memWords = uartBase; // whole space below the port registers

	portStatusT [1:0] portStatus;
	logic [1:0]       txStart;
	logic [1:0]       rxClear;
	logic [1:0]       rxReady;
	logic [7:0]       txData;
	logic [7:0]       rxData0;
	logic [7:0]       rxData1;
	logic [7:0]       statusWord;
	logic [11:0]      memAddr;
	logic [1:0]       memSrc;
	logic             memWe;
	logic             rdIsStatus;
	logic             rdEn;

	assign rdEn = busReq.op == opRead;

	portArbiter iPortArbiter (
		.KEY        (KEY),
		.rstN       (rstN),
		.busReq     (busReq),
		.status     (portStatus),
		.rxReady    (rxReady),
		.txStart    (txStart),
		.txData     (txData),
		.rxClear    (rxClear),
		.memWe      (memWe),
		.memAddr    (memAddr),
		.memSrc     (memSrc),
		.rdIsStatus (rdIsStatus),
		.statusWord (statusWord)
	);

	dataMemory #(.memWords(memWords)) iDataMemory (
		.KEY        (KEY),
		.rstN       (rstN),
		.busData    (busReq.wrData),
		.rxData0    (rxData0),
		.rxData1    (rxData1),
		.memWe      (memWe),
		.memAddr    (memAddr),
		.memSrc     (memSrc),
		.rdEn       (rdEn),
		.rdIsStatus (rdIsStatus),
		.statusWord (statusWord),
		.rdData     (rdData),
		.rdValid    (rdValid)
	);

	uartPort #(.clksPerBit(clksPerBit)) iUartPort0 (
		.KEY     (KEY),
		.rstN    (rstN),
		.txStart (txStart[0]),
		.txData  (txData),
		.rxClear (rxClear[0]),
		.rxLine  (rxLine[0]),
		.txLine  (txLine[0]),
		.rxReady (rxReady[0]),
		.rxData  (rxData0),
		.status  (portStatus[0])
	);

	uartPort #(.clksPerBit(clksPerBit)) iUartPort1 (
		.KEY     (KEY),
		.rstN    (rstN),
		.txStart (txStart[1]),
		.txData  (txData),
		.rxClear (rxClear[1]),
		.rxLine  (rxLine[1]),
		.txLine  (txLine[1]),
		.rxReady (rxReady[1]),
		.rxData  (rxData1),
		.status  (portStatus[1])
	);

endmodule

// File: verification/serialBridgeTb.sv
`timescale 1ns/1ps
module serialBridgeTb;
	import busPkg::*;

	localparam int clksPerBit = 8;
	localparam int waitLimit  = 200; // cycles a single wait may take

	logic        KEY;
	logic        rstN;
	busReqT      busReq;
	logic [1:0]  rxLine;
	logic [1:0]  txLine;
	logic [7:0]  rdData;
	logic        rdValid;

	logic [7:0]  memModel [2048];
	logic [7:0]  expQ [$];
	bit          chkQ [$];    // 0 marks a polling read
	logic [11:0] wrAddrQ [$];
	logic [15:0] lfsr = 16'd74;
	logic [7:0]  lastRd;
	logic [7:0]  expVal;
	logic        readDue = 1'b0; // a read was on the bus at the last edge
	int          readErrors = 0;
	int          lineErrors = 0;
	int          timeoutErrors = 0;

	serialBridgeTop #(.clksPerBit(clksPerBit)) i_serialBridgeTop (
		.KEY     (KEY),
		.rstN    (rstN),
		.busReq  (busReq),
		.rxLine  (rxLine),
		.txLine  (txLine),
		.rdData  (rdData),
		.rdValid (rdValid)
	);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] randBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// start bit first, stop bit last
	function automatic logic [9:0] frameBits(input logic [7:0] data);
		return {1'b1, data, 1'b0};
	endfunction

	function automatic logic [7:0] statusRef(input logic busy1, input logic ovr1,
			input logic busy0, input logic ovr0);
		return {4'b0000, busy1, ovr1, busy0, ovr0};
	endfunction

	initial begin
		KEY = 1'b0;
		forever #4 KEY = ~KEY;
	end

	always @(posedge KEY) begin
		readDue <= busReq.op == opRead;
	end

	// every read answer is checked half a cycle after it appears
	always @(negedge KEY) begin
		if (rstN && rdValid !== readDue) begin
			readErrors++;
			$display("Fail at %0t ns: rdValid expected %b, got %b", $time, readDue, rdValid);
		end
		if (rstN && rdValid) begin
			if (expQ.size() == 0) begin
				readErrors++;
				$display("rdValid at %0t ns with no read outstanding", $time);
			end else begin
				expVal = expQ.pop_front();
				lastRd = rdData;
				if (chkQ.pop_front() && rdData !== expVal) begin
					readErrors++;
					$display("Fail at %0t ns: rdData expected 0x%h, got 0x%h", $time,
						expVal, rdData);
				end
			end
		end
	end

	task automatic drive(input busOpT op, input logic [11:0] addr, input logic [7:0] data);
		@(posedge KEY);
		busReq.op     <= op;
		busReq.addr   <= addr;
		busReq.wrData <= data;
	endtask

	task automatic busIdle();
		drive(opIdle, 12'h000, 8'h00);
	endtask

	task automatic memWrite(input logic [11:0] addr, input logic [7:0] data);
		drive(opWrite, addr, data);
		memModel[addr] = data;
	endtask

	task automatic readCheck(input logic [11:0] addr, input logic [7:0] val);
		expQ.push_back(val);
		chkQ.push_back(1'b1);
		drive(opRead, addr, 8'h00);
	endtask

	// idle cycles between polls leave room for the store
	task automatic waitMailbox(input logic [11:0] addr, input logic [7:0] val);
		int n;
		n = 0;
		lastRd = ~val;
		while (lastRd !== val && n < waitLimit) begin
			expQ.push_back(8'h00);
			chkQ.push_back(1'b0);
			drive(opRead, addr, 8'h00);
			busIdle();
			@(posedge KEY); // answer taken on the negedge before
			n++;
		end
		if (lastRd !== val) begin
			timeoutErrors++;
			$display("timeout: mailbox 0x%h never received 0x%h", addr, val);
		end
	endtask

	task automatic sendFrame(input int port, input logic [7:0] data);
		logic [9:0] bits;
		bits = frameBits(data);
		for (int k = 0; k < 10; k++) begin
			@(posedge KEY);
			rxLine[port] <= bits[k];
			repeat (clksPerBit - 1) @(posedge KEY);
		end
	endtask

	task automatic checkFrame(input int port, input logic [7:0] data);
		logic [9:0] bits;
		int n;
		bits = frameBits(data);
		n = 0;
		@(negedge KEY);
		while (txLine[port] !== 1'b0 && n < waitLimit) begin
			@(negedge KEY);
			n++;
		end
		if (txLine[port] !== 1'b0) begin
			timeoutErrors++;
			$display("timeout: no start bit on txLine[%0d]", port);
		end else begin
			for (int k = 0; k < 10 * clksPerBit; k++) begin
				if (txLine[port] !== bits[k / clksPerBit]) begin
					lineErrors++;
					$display("Fail at %0t ns: txLine[%0d] expected %b, got %b", $time, port,
						bits[k / clksPerBit], txLine[port]);
				end
				@(negedge KEY);
			end
		end
	endtask

	// line must stay idle, the dropped byte is never sent
	task automatic checkQuiet(input int port, input int cycles);
		for (int k = 0; k < cycles; k++) begin
			if (txLine[port] !== 1'b1) begin
				lineErrors++;
				$display("Fail at %0t ns: txLine[%0d] expected 1, got %b", $time, port, txLine[port]);
			end
			@(negedge KEY);
		end
	endtask

	initial begin
		logic [15:0] r;
		logic [11:0] a;
		logic [7:0]  d;
		logic [7:0]  d2;
		int          n;
		rstN   = 1'b0;
		busReq = '0;
		rxLine = 2'b11;
		repeat (16) @(posedge KEY);
		rstN <= 1'b1;
		busIdle();

		for (int i = 0; i < 60; i++) begin // memory round trip
			r = randBits(1);
			if (r[0] || wrAddrQ.size() == 0) begin
				a = 12'(randBits(11));
				d = 8'(randBits(8));
				memWrite(a, d);
				wrAddrQ.push_back(a);
			end else begin
				a = wrAddrQ[randBits(6) % wrAddrQ.size()];
				readCheck(a, memModel[a]);
			end
		end
		busIdle();

		for (int p = 0; p < 2; p++) begin // framing and busy on each port
			d = 8'(randBits(8));
			fork
				checkFrame(p, d);
				begin
					drive(opWrite, uartBase + 12'(p), d);
					busIdle();
					repeat (20) @(posedge KEY);
					readCheck(statusAddr, p == 0 ? statusRef(0, 0, 1, 0) : statusRef(1, 0, 0, 0));
					busIdle();
				end
			join
			readCheck(statusAddr, statusRef(0, 0, 0, 0));
			busIdle();
		end

		d = 8'(randBits(8));
		d2 = 8'(randBits(8));
		fork
			checkFrame(0, d);
			begin
				drive(opWrite, uartBase, d);
				busIdle();
				repeat (10) @(posedge KEY);
				drive(opWrite, uartBase, d2); // port 0 still busy
				readCheck(statusAddr, statusRef(0, 0, 1, 1));
				readCheck(statusAddr, statusRef(0, 0, 1, 0));
				busIdle();
			end
		join
		checkQuiet(0, 3 * clksPerBit);
		readCheck(statusAddr, statusRef(0, 0, 0, 0));
		busIdle();

		d = 8'(randBits(8)); // both ports receive at once
		d2 = 8'(randBits(8));
		memWrite(mailbox0, ~d);
		memWrite(mailbox1, ~d2);
		busIdle();
		fork
			sendFrame(0, d);
			sendFrame(1, d2);
		join
		waitMailbox(mailbox0, d);
		waitMailbox(mailbox1, d2);
		readCheck(mailbox0, d);
		readCheck(mailbox1, d2);
		busIdle();

		d = 8'(randBits(8)); // store held back by bus writes
		memWrite(mailbox0, ~d);
		wrAddrQ.delete();
		fork
			sendFrame(0, d);
			for (int i = 0; i < 12 * clksPerBit; i++) begin
				a = 12'(randBits(10));
				memWrite(a, 8'(randBits(8)));
				wrAddrQ.push_back(a);
			end
		join
		busIdle();
		waitMailbox(mailbox0, d);
		readCheck(mailbox0, d);
		foreach (wrAddrQ[i]) readCheck(wrAddrQ[i], memModel[wrAddrQ[i]]);
		busIdle();

		n = 0;
		while (expQ.size() != 0 && n < waitLimit) begin
			@(posedge KEY);
			n++;
		end
		if (expQ.size() != 0) begin
			timeoutErrors++;
			$display("timeout: %0d read answers never arrived", expQ.size());
		end
		$display("errors: read %0d, serial line %0d, timeout %0d", readErrors, lineErrors,
			timeoutErrors);
		if (readErrors + lineErrors + timeoutErrors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: filelist.f
src/busPkg.sv
src/serialPkg.sv
src/uartTx.sv
src/uartRx.sv
src/uartPort.sv
src/portArbiter.sv
src/dataMemory.sv
src/serialBridgeTop.sv
verification/serialBridgeTb.sv

// File: Bender.yml
package:
  name: serialBridge

sources:
  - src/busPkg.sv
  - src/serialPkg.sv
  - src/uartTx.sv
  - src/uartRx.sv
  - src/uartPort.sv
  - src/portArbiter.sv
  - src/dataMemory.sv
  - src/serialBridgeTop.sv
  - target: test
    files:
      - verification/serialBridgeTb.sv
